/* wbxb.f */
hdl/wbxb_pkg.sv
hdl/wbxb_bus_if.sv
hdl/wbxb_round_robin_core.sv
hdl/wbxb_round_robin.sv
hdl/wbxb_addr_decode.sv
hdl/wbxb_switch.sv
hdl/wbxb_ram_slave.sv
hdl/wbxb_top.sv
testbench/wbxb_tb.sv

/* Makefile */
TOP = wbxb_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f wbxb.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > sim.log 2>&1; cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/wbxb_tb.sv */
`timescale 1ns/1ps

module wbxb_tb import wbxb_pkg::*; ();

	localparam int    RAM_DEPTH = 1024;
	localparam int    N_RAND    = 24; // accesses per master in the random test.
	localparam int    PLANNED   = 4 + 5 + 4 + 9 + 5 + MST_NB * N_RAND;
	localparam prio_t PRIO [MST_NB] = '{2'd0, 2'd0, 2'd0, 2'd1};

	typedef struct {
		int       m;
		wb_addr_t adr;
		logic     we;
		wb_data_t dat_w;
		wb_sel_t  sel;
		mst_vec_t ack;
		mst_vec_t err;
		wb_data_t dat_r;
		int       edges;  // rising edges from the drive edge to the response.
		bit       solo;
	} access_t;

	logic     aclk;
	logic     rst_n;
	mst_vec_t m_cyc;
	mst_vec_t m_stb;
	mst_vec_t m_we;
	wb_addr_t m_adr   [MST_NB];
	wb_data_t m_dat_w [MST_NB];
	wb_sel_t  m_sel   [MST_NB];
	wb_data_t m_dat_r [MST_NB];
	mst_vec_t m_ack;
	mst_vec_t m_err;

	wb_data_t ref_mem [SLV_NB][RAM_DEPTH];
	mst_vec_t rr_mask [SLV_NB][4];  // per slave and level, as seen by the model.
	access_t  done_q [$];
	int       order_q [$];
	int       exp_order [$];
	int       order_slave = -1;
	int       err_count   = 0;
	int       check_count = 0;
	int       test_count  = 0;
	int       err_mark    = 0;

	wb_addr_t rnd_adr [MST_NB][N_RAND];
	logic     rnd_we  [MST_NB][N_RAND];
	wb_data_t rnd_dat [MST_NB][N_RAND];
	wb_sel_t  rnd_sel [MST_NB][N_RAND];

	wbxb_top #(
		.REQ0_PRIORITY (PRIO[0]),
		.REQ1_PRIORITY (PRIO[1]),
		.REQ2_PRIORITY (PRIO[2]),
		.REQ3_PRIORITY (PRIO[3]),
		.RAM_DEPTH     (RAM_DEPTH)
	) UUT (
		.aclk    (aclk),
		.rst_n   (rst_n),
		.m_cyc   (m_cyc),
		.m_stb   (m_stb),
		.m_we    (m_we),
		.m_adr   (m_adr),
		.m_dat_w (m_dat_w),
		.m_sel   (m_sel),
		.m_dat_r (m_dat_r),
		.m_ack   (m_ack),
		.m_err   (m_err)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// ##########################################################################
	// reference model
	// ##########################################################################

	function automatic mst_vec_t onehot(int m);
		return mst_vec_t'(1) << m;
	endfunction

	// slave index, or -1 outside both windows.
	function automatic int slave_of(wb_addr_t adr);
		for (int s = 0; s < SLV_NB; s++) begin
			if (adr >= SLV_BASE[s] && (adr - SLV_BASE[s]) < SLV_SPAN) begin
				return s;
			end
		end
		return -1;
	endfunction

	function automatic wb_data_t merge_lanes(wb_data_t old, wb_data_t wr, wb_sel_t sel);
		wb_data_t res;
		res = old;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = wr[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// lowest request after the last winner, else the lowest request.
	function automatic mst_vec_t rr_pick(mst_vec_t req, mst_vec_t mask);
		for (int i = 0; i < MST_NB; i++) begin
			if (req[i] && mask[i]) begin
				return onehot(i);
			end
		end
		for (int i = 0; i < MST_NB; i++) begin
			if (req[i]) begin
				return onehot(i);
			end
		end
		return '0;
	endfunction

	function automatic mst_vec_t mask_after(int w);
		mst_vec_t mask;
		for (int i = 0; i < MST_NB; i++) begin
			mask[i] = (i > w);
		end
		return mask;
	endfunction

	// serving order when every master keeps its strobe up until its count is used.
	function automatic void predict_order(int s, int pend_in [MST_NB]);
		int       pend [MST_NB];
		mst_vec_t lvl_mask [4];
		mst_vec_t req;
		mst_vec_t lvl_req;
		mst_vec_t g;
		int       total;
		int       last;
		int       w;
		total = 0;
		for (int m = 0; m < MST_NB; m++) begin
			pend[m] = pend_in[m];
			total += pend[m];
		end
		for (int l = 0; l < 4; l++) begin
			lvl_mask[l] = rr_mask[s][l];
		end
		exp_order.delete();
		last = -1;
		repeat (total) begin
			req = '0;
			for (int m = 0; m < MST_NB; m++) begin
				req[m] = (pend[m] > 0) && (m != last); // the master in its ack cycle waits.
			end
			if (req == '0) begin
				req = onehot(last);
			end
			g = '0;
			for (int l = 3; l >= 0; l--) begin
				lvl_req = '0;
				for (int m = 0; m < MST_NB; m++) begin
					lvl_req[m] = req[m] && (PRIO[m] == prio_t'(l));
				end
				if (g == '0 && lvl_req != '0) begin
					g = rr_pick(lvl_req, lvl_mask[l]);
				end
			end
			w = 0;
			for (int m = 0; m < MST_NB; m++) begin
				if (g[m]) begin
					w = m;
				end
			end
			exp_order.push_back(w);
			lvl_mask[PRIO[w]] = mask_after(w);
			pend[w]--;
			last = w;
		end
	endfunction

	// ##########################################################################
	// compare tasks
	// ##########################################################################

	task automatic check_data(string name, wb_data_t got, wb_data_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flag(string name, mst_vec_t got, mst_vec_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_order(string name, int got [$], int exp [$]);
		check_count++;
		if (got.size() != exp.size()) begin
			err_count++;
			$display("%s has %0d responses, %0d expected", name, got.size(), exp.size());
		end else begin
			for (int i = 0; i < got.size(); i++) begin
				if (got[i] != exp[i]) begin
					err_count++;
					$display("%s differs at position %0d: master %0d served, master %0d due",
						name, i, got[i], exp[i]);
					break;
				end
			end
		end
	endtask

	task automatic check_edges(int m, int got, int exp);
		check_count++;
		if (got != exp) begin
			err_count++;
			$display("master %0d answered %0d edges after its request, %0d expected", m, got, exp);
		end
	endtask

	task automatic check_access(access_t r);
		int s;
		int w;
		s = slave_of(r.adr);
		if (s < 0) begin
			check_flag("m_ack", r.ack, '0);
			check_flag("m_err", r.err, onehot(r.m));
		end else begin
			check_flag("m_ack", r.ack, onehot(r.m));
			check_flag("m_err", r.err, '0);
			w = int'((r.adr - SLV_BASE[s]) >> 2);
			if (r.we) begin
				ref_mem[s][w] = merge_lanes(ref_mem[s][w], r.dat_w, r.sel);
			end else begin
				check_data($sformatf("m_dat_r[%0d]", r.m), r.dat_r, ref_mem[s][w]);
			end
			rr_mask[s][PRIO[r.m]] = mask_after(r.m);
			if (s == order_slave) begin
				order_q.push_back(r.m);
			end
		end
		if (r.solo) begin
			check_edges(r.m, r.edges, (s < 0) ? 1 : 2);
		end
	endtask

	initial begin : compare
		access_t r;
		forever begin
			@(posedge aclk);
			while (done_q.size() != 0) begin
				r = done_q.pop_front();
				check_access(r);
			end
		end
	end

	// ##########################################################################
	// master side
	// ##########################################################################

	task automatic bus_access(int m, wb_addr_t adr, logic we, wb_data_t dat, wb_sel_t sel, bit solo);
		access_t r;
		int      n;
		@(posedge aclk);
		m_cyc[m]   <= 1'b1;
		m_stb[m]   <= 1'b1;
		m_we[m]    <= we;
		m_adr[m]   <= adr;
		m_dat_w[m] <= dat;
		m_sel[m]   <= sel;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (!m_ack[m] && !m_err[m]);
		r.m     = m;
		r.adr   = adr;
		r.we    = we;
		r.dat_w = dat;
		r.sel   = sel;
		r.ack   = m_ack & onehot(m);
		r.err   = m_err & onehot(m);
		r.dat_r = m_dat_r[m];
		r.edges = n - 1;
		r.solo  = solo;
		done_q.push_back(r);
		@(posedge aclk);
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
		m_we[m]  <= 1'b0;
	endtask

	task automatic burst(int m, int s, int n, logic we);
		for (int i = 0; i < n; i++) begin
			bus_access(m, SLV_BASE[s] + 32'h100 + wb_addr_t'((m * 16 + i) * 4), we,
				{8'(m), 8'(i), 16'hc0de}, 4'hf, 1'b0);
		end
	endtask

	task automatic random_run(int m);
		for (int i = 0; i < N_RAND; i++) begin
			bus_access(m, rnd_adr[m][i], rnd_we[m][i], rnd_dat[m][i], rnd_sel[m][i], 1'b0);
		end
	endtask

	task automatic drain_checks();
		do begin
			@(negedge aclk);
		end while (done_q.size() != 0);
	endtask

	task automatic end_test(string name);
		test_count++;
		if (err_count == err_mark) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			$display("test %0d %s: %0d errors", test_count, name, err_count - err_mark);
		end
		err_mark = err_count;
	endtask

	initial begin : watchdog
		repeat (PLANNED * 200) @(posedge aclk);
		$display("timeout: no end of run after %0d cycles", PLANNED * 200);
		$display("Testbench failed");
		$finish;
	end

	// ##########################################################################
	// tests
	// ##########################################################################

	initial begin : stimulus
		int pend [MST_NB];
		int pick;
		void'($urandom(32'h550f85ea));
		rst_n = 1'b0;
		m_cyc = '0;
		m_stb = '0;
		m_we  = '0;
		for (int m = 0; m < MST_NB; m++) begin
			m_adr[m]   = '0;
			m_dat_w[m] = '0;
			m_sel[m]   = '0;
		end
		for (int s = 0; s < SLV_NB; s++) begin
			for (int i = 0; i < RAM_DEPTH; i++) begin
				ref_mem[s][i] = '0; // ram is cleared by reset.
			end
			for (int l = 0; l < 4; l++) begin
				rr_mask[s][l] = '1;
			end
		end
		repeat (4) @(posedge aclk);
		rst_n <= 1'b1;

		@(negedge aclk);
		check_flag("m_ack", m_ack, '0);
		check_flag("m_err", m_err, '0);
		bus_access(0, 32'h0000_0004, 1'b1, 32'hdead_beef, 4'hf, 1'b1);
		bus_access(0, 32'h0000_0004, 1'b0, '0, 4'hf, 1'b1);
		bus_access(0, 32'h0000_1008, 1'b1, 32'h0123_4567, 4'hf, 1'b1);
		bus_access(0, 32'h0000_1008, 1'b0, '0, 4'hf, 1'b1);
		drain_checks();
		end_test("write then read");

		bus_access(1, 32'h0000_1020, 1'b1, 32'h1122_3344, 4'hf, 1'b0);
		bus_access(1, 32'h0000_1020, 1'b1, 32'haabb_ccdd, 4'b0101, 1'b0);
		bus_access(2, 32'h0000_0030, 1'b1, 32'h5566_7788, 4'b0110, 1'b0);
		bus_access(1, 32'h0000_1020, 1'b0, '0, 4'hf, 1'b0);
		bus_access(2, 32'h0000_0030, 1'b0, '0, 4'hf, 1'b0);
		drain_checks();
		end_test("byte select");

		bus_access(0, 32'h0000_2010, 1'b1, 32'hffff_ffff, 4'hf, 1'b1);
		bus_access(1, 32'h8000_0000, 1'b0, '0, 4'hf, 1'b1);
		bus_access(0, 32'h0000_0010, 1'b0, '0, 4'hf, 1'b0);
		bus_access(0, 32'h0000_1010, 1'b0, '0, 4'hf, 1'b0);
		drain_checks();
		end_test("unmapped address");

		order_slave = 0;
		order_q.delete();
		pend = '{3, 3, 3, 0};
		predict_order(0, pend);
		fork
			burst(0, 0, 3, 1'b1);
			burst(1, 0, 3, 1'b1);
			burst(2, 0, 3, 1'b1);
		join
		drain_checks();
		check_order("slave 0 ack order", order_q, exp_order);
		end_test("round-robin contention");

		order_slave = 1;
		order_q.delete();
		pend = '{1, 1, 1, 2};
		predict_order(1, pend);
		fork
			burst(0, 1, 1, 1'b0);
			burst(1, 1, 1, 1'b0);
			burst(2, 1, 1, 1'b0);
			burst(3, 1, 2, 1'b1);
		join
		drain_checks();
		check_order("slave 1 ack order", order_q, exp_order);
		end_test("priority level");

		order_slave = -1;
		for (int m = 0; m < MST_NB; m++) begin
			for (int i = 0; i < N_RAND; i++) begin
				pick = $urandom_range(0, 4);
				if (pick == 4) begin
					rnd_adr[m][i] = ($urandom() | 32'h0000_2000) & ~32'h3;
				end else begin
					rnd_adr[m][i] = SLV_BASE[pick % 2] + wb_addr_t'($urandom_range(0, 15) * 4);
				end
				rnd_we[m][i]  = 1'($urandom_range(0, 1));
				rnd_dat[m][i] = $urandom();
				rnd_sel[m][i] = 4'($urandom_range(1, 15));
			end
		end
		fork
			random_run(0);
			random_run(1);
			random_run(2);
			random_run(3);
		join
		drain_checks();
		end_test("random traffic");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* hdl/wbxb_top.sv */
`timescale 1ns/1ps

module wbxb_top import wbxb_pkg::*; #(
	parameter prio_t REQ0_PRIORITY = 2'd0,
	parameter prio_t REQ1_PRIORITY = 2'd0,
	parameter prio_t REQ2_PRIORITY = 2'd0,
	parameter prio_t REQ3_PRIORITY = 2'd0,
	parameter int    RAM_DEPTH     = 1024
) (
	input  logic     aclk,
	input  logic     rst_n,
	input  mst_vec_t m_cyc,
	input  mst_vec_t m_stb,
	input  mst_vec_t m_we,
	input  wb_addr_t m_adr   [MST_NB],
	input  wb_data_t m_dat_w [MST_NB],
	input  wb_sel_t  m_sel   [MST_NB],
	output wb_data_t m_dat_r [MST_NB],
	output mst_vec_t m_ack,
	output mst_vec_t m_err
);

	slv_idx_t slv_sel [MST_NB];
	mst_vec_t unmapped;

	wbxb_bus_if mst_bus [MST_NB] ();
	wbxb_bus_if slv_bus [SLV_NB] ();

	// ##########################################################################
	// master ports onto the internal buses
	// ##########################################################################

	for (genvar m = 0; m < MST_NB; m++) begin : g_mst
		assign mst_bus[m].cyc   = m_cyc[m];
		assign mst_bus[m].stb   = m_stb[m];
		assign mst_bus[m].we    = m_we[m];
		assign mst_bus[m].adr   = m_adr[m];
		assign mst_bus[m].dat_w = m_dat_w[m];
		assign mst_bus[m].sel   = m_sel[m];

		assign m_dat_r[m] = mst_bus[m].dat_r;
		assign m_ack[m]   = mst_bus[m].ack;
		assign m_err[m]   = mst_bus[m].err;
	end

	wbxb_addr_decode u_decode (
		.adr      (m_adr),
		.slv      (slv_sel),
		.unmapped (unmapped)
	);

	wbxb_switch #(
		.REQ0_PRIORITY (REQ0_PRIORITY),
		.REQ1_PRIORITY (REQ1_PRIORITY),
		.REQ2_PRIORITY (REQ2_PRIORITY),
		.REQ3_PRIORITY (REQ3_PRIORITY)
	) u_switch (
		.aclk     (aclk),
		.rst_n    (rst_n),
		.mst      (mst_bus),
		.slv      (slv_bus),
		.slv_sel  (slv_sel),
		.unmapped (unmapped)
	);

	for (genvar s = 0; s < SLV_NB; s++) begin : g_ram
		wbxb_ram_slave #(
			.DEPTH (RAM_DEPTH)
		) u_ram (
			.aclk  (aclk),
			.rst_n (rst_n),
			.bus   (slv_bus[s])
		);
	end

endmodule

/* hdl/wbxb_ram_slave.sv */
`timescale 1ns/1ps

module wbxb_ram_slave import wbxb_pkg::*; #(
	parameter int DEPTH = 1024
) (
	input  logic      aclk,
	input  logic      rst_n,
	wbxb_bus_if.slave bus
);

	localparam int LANE_W = DATA_W / SEL_W;
	localparam int OFS_W  = $clog2(SEL_W);               // byte offset bits.
	localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	wb_data_t         mem [DEPTH];
	logic [IDX_W-1:0] idx;
	logic             access;
	logic             ack_q;
	wb_data_t         rdata_q;

	// word address within the window.
	assign idx    = bus.adr[IDX_W+OFS_W-1:OFS_W];
	assign access = bus.cyc & bus.stb;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			ack_q <= access; // the switch drops stb while ack is up.
			if (access && bus.we) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (bus.sel[b]) begin
						mem[idx][b*LANE_W +: LANE_W] <= bus.dat_w[b*LANE_W +: LANE_W];
					end
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (access) begin
			rdata_q <= mem[idx];
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rdata_q;
	assign bus.err   = 1'b0;   // every word in the window exists.

endmodule

/* hdl/wbxb_switch.sv */
`timescale 1ns/1ps

module wbxb_switch import wbxb_pkg::*; #(
	parameter prio_t REQ0_PRIORITY = 2'd0,
	parameter prio_t REQ1_PRIORITY = 2'd0,
	parameter prio_t REQ2_PRIORITY = 2'd0,
	parameter prio_t REQ3_PRIORITY = 2'd0
) (
	input  logic       aclk,
	input  logic       rst_n,
	wbxb_bus_if.slave  mst [MST_NB],
	wbxb_bus_if.master slv [SLV_NB],
	input  slv_idx_t   slv_sel [MST_NB],
	input  mst_vec_t   unmapped
);

	mst_vec_t m_cyc;
	mst_vec_t m_stb;
	mst_vec_t m_we;
	wb_addr_t m_adr   [MST_NB];
	wb_data_t m_dat_w [MST_NB];
	wb_sel_t  m_sel   [MST_NB];
	wb_data_t m_dat_r [MST_NB];
	mst_vec_t m_ack;
	mst_vec_t m_err;
	mst_vec_t err_q;                 // unmapped access response.

	logic [SLV_NB-1:0] s_ack;
	logic [SLV_NB-1:0] s_err;
	wb_data_t          s_dat_r   [SLV_NB];
	mst_vec_t          s_req     [SLV_NB];
	mst_vec_t          arb_grant [SLV_NB];
	mst_vec_t          gnt_q     [SLV_NB]; // owner, held until ack.
	mst_vec_t          gnt_live  [SLV_NB]; // owner, dropped during ack.
	logic [SLV_NB-1:0] arb_en;

	// ##########################################################################
	// requests and arbitration
	// ##########################################################################

	// a master just acked is left out, its stb is still up this cycle.
	always_comb begin
		for (int s = 0; s < SLV_NB; s++) begin
			for (int m = 0; m < MST_NB; m++) begin
				s_req[s][m] = m_cyc[m] & m_stb[m] & ~unmapped[m] & ~m_ack[m]
					& (slv_sel[m] == slv_idx_t'(s));
			end
		end
	end

	for (genvar s = 0; s < SLV_NB; s++) begin : g_slv
		assign s_ack[s]    = slv[s].ack;
		assign s_err[s]    = slv[s].err;
		assign s_dat_r[s]  = slv[s].dat_r;
		assign gnt_live[s] = (s_ack[s] || s_err[s]) ? '0 : gnt_q[s];
		assign arb_en[s]   = ~|gnt_live[s];

		wbxb_round_robin #(
			.REQ_NB        (MST_NB),
			.REQ0_PRIORITY (REQ0_PRIORITY),
			.REQ1_PRIORITY (REQ1_PRIORITY),
			.REQ2_PRIORITY (REQ2_PRIORITY),
			.REQ3_PRIORITY (REQ3_PRIORITY)
		) u_arb (
			.aclk  (aclk),
			.rst_n (rst_n),
			.en    (arb_en[s]),
			.req   (s_req[s]),
			.grant (arb_grant[s])
		);

		always_ff @(posedge aclk) begin
			if (!rst_n) begin
				gnt_q[s] <= '0;
			end else if (arb_en[s]) begin
				gnt_q[s] <= arb_grant[s]; // zero when nobody waits.
			end
		end

		// steer the owner onto the slave bus.
		always_comb begin
			slv[s].cyc   = 1'b0;
			slv[s].stb   = 1'b0;
			slv[s].we    = 1'b0;
			slv[s].adr   = '0;
			slv[s].dat_w = '0;
			slv[s].sel   = '0;
			for (int m = 0; m < MST_NB; m++) begin
				if (gnt_live[s][m]) begin
					slv[s].cyc   = m_cyc[m];
					slv[s].stb   = m_stb[m];
					slv[s].we    = m_we[m];
					slv[s].adr   = m_adr[m];
					slv[s].dat_w = m_dat_w[m];
					slv[s].sel   = m_sel[m];
				end
			end
		end
	end

	// ##########################################################################
	// responses
	// ##########################################################################

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			err_q <= '0;
		end else begin
			err_q <= m_cyc & m_stb & unmapped & ~err_q;
		end
	end

	always_comb begin
		for (int m = 0; m < MST_NB; m++) begin
			m_ack[m]   = 1'b0;
			m_err[m]   = err_q[m];
			m_dat_r[m] = '0;
			for (int s = 0; s < SLV_NB; s++) begin
				if (gnt_q[s][m]) begin
					m_ack[m]   = s_ack[s];
					m_err[m]   = err_q[m] | s_err[s];
					m_dat_r[m] = s_dat_r[s];
				end
			end
		end
	end

	for (genvar m = 0; m < MST_NB; m++) begin : g_mst
		logic [SLV_NB-1:0] owner;   // slaves holding a grant for this master.

		assign m_cyc[m]   = mst[m].cyc;
		assign m_stb[m]   = mst[m].stb;
		assign m_we[m]    = mst[m].we;
		assign m_adr[m]   = mst[m].adr;
		assign m_dat_w[m] = mst[m].dat_w;
		assign m_sel[m]   = mst[m].sel;

		assign mst[m].dat_r = m_dat_r[m];
		assign mst[m].ack   = m_ack[m];
		assign mst[m].err   = m_err[m];

		always_comb begin
			for (int s = 0; s < SLV_NB; s++) begin
				owner[s] = gnt_q[s][m];
			end
		end

		a_single_owner: assert property (@(posedge aclk) disable iff (!rst_n)
			$onehot0(owner));

		a_ack_xor_err: assert property (@(posedge aclk) disable iff (!rst_n)
			!(m_ack[m] && m_err[m]));
	end

endmodule

/* hdl/wbxb_addr_decode.sv */
`timescale 1ns/1ps

module wbxb_addr_decode import wbxb_pkg::*; (
	input  wb_addr_t adr [MST_NB],
	output slv_idx_t slv [MST_NB],
	output mst_vec_t unmapped
);

	function automatic logic in_window(wb_addr_t a, int s);
		logic above;
		logic below;
		above = (a >= SLV_BASE[s]);
		below = ((a - SLV_BASE[s]) < SLV_SPAN);
		return above && below;
	endfunction

	// ##########################################################################
	// per master lookup
	// ##########################################################################

	always_comb begin
		for (int m = 0; m < MST_NB; m++) begin
			slv[m]      = '0;
			unmapped[m] = 1'b1; // cleared by the first window hit.
			for (int s = 0; s < SLV_NB; s++) begin
				if (in_window(adr[m], s)) begin
					slv[m]      = slv_idx_t'(s);
					unmapped[m] = 1'b0;
				end
			end
		end
	end

endmodule

/* hdl/wbxb_round_robin.sv */
`timescale 1ns/1ps

module wbxb_round_robin import wbxb_pkg::*; #(
	parameter int    REQ_NB        = MST_NB,
	parameter prio_t REQ0_PRIORITY = 2'd0,
	parameter prio_t REQ1_PRIORITY = 2'd0,
	parameter prio_t REQ2_PRIORITY = 2'd0,
	parameter prio_t REQ3_PRIORITY = 2'd0
) (
	input  logic              aclk,
	input  logic              rst_n,
	input  logic              en,
	input  logic [REQ_NB-1:0] req,
	output logic [REQ_NB-1:0] grant
);

	localparam int LVL_NB = 4;

	localparam prio_t [LVL_NB-1:0] PRIO = {
		REQ3_PRIORITY,
		REQ2_PRIORITY,
		REQ1_PRIORITY,
		REQ0_PRIORITY
	};

	logic [REQ_NB-1:0] lvl_req   [LVL_NB];
	logic [REQ_NB-1:0] lvl_grant [LVL_NB];
	logic [LVL_NB-1:0] lvl_any;
	logic [LVL_NB-1:0] lvl_win;   // one-hot, highest level with a request.

	if (REQ_NB > LVL_NB) begin : g_bad_cfg
		$error("wbxb_round_robin: one priority per requester, four at most");
	end

	// split the requests by static level.
	always_comb begin
		for (int l = 0; l < LVL_NB; l++) begin
			for (int i = 0; i < REQ_NB; i++) begin
				lvl_req[l][i] = (PRIO[i] == prio_t'(l)) ? req[i] : 1'b0;
			end
			lvl_any[l] = |lvl_req[l];
		end
	end

	always_comb begin
		lvl_win = '0;
		for (int l = LVL_NB - 1; l >= 0; l--) begin
			if (lvl_any[l] && !(|lvl_win)) begin
				lvl_win[l] = 1'b1;
			end
		end
	end

	for (genvar l = 0; l < LVL_NB; l++) begin : g_lvl
		localparam bit USED = (REQ_NB > 0 && REQ0_PRIORITY == l) ||
			(REQ_NB > 1 && REQ1_PRIORITY == l) ||
			(REQ_NB > 2 && REQ2_PRIORITY == l) ||
			(REQ_NB > 3 && REQ3_PRIORITY == l);

		if (USED) begin : g_on
			// only the winning level moves its mask.
			wbxb_round_robin_core #(
				.REQ_NB(REQ_NB)
			) u_core (
				.aclk  (aclk),
				.rst_n (rst_n),
				.en    (en & lvl_win[l]),
				.req   (lvl_req[l]),
				.grant (lvl_grant[l])
			);
		end else begin : g_off
			assign lvl_grant[l] = '0;
		end
	end

	always_comb begin
		grant = '0;
		for (int l = 0; l < LVL_NB; l++) begin
			if (lvl_win[l]) begin
				grant = lvl_grant[l];
			end
		end
	end

endmodule

/* hdl/wbxb_round_robin_core.sv */
`timescale 1ns/1ps

module wbxb_round_robin_core #(
	parameter int REQ_NB = 4
) (
	input  logic              aclk,
	input  logic              rst_n,
	input  logic              en,
	input  logic [REQ_NB-1:0] req,
	output logic [REQ_NB-1:0] grant
);

	localparam logic [REQ_NB-1:0] ONE = REQ_NB'(1);

	logic [REQ_NB-1:0] mask;       // requesters ranked after the last winner.
	logic [REQ_NB-1:0] req_masked;
	logic [REQ_NB-1:0] mask_nxt;

	assign req_masked = req & mask;

	// lowest set bit wins, masked requests first.
	always_comb begin
		if (|req_masked) begin
			grant = req_masked & (~req_masked + ONE);
		end else begin
			grant = req & (~req + ONE);
		end
	end

	// every bit above the one-hot winner.
	assign mask_nxt = ~((grant << 1) - ONE);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			mask <= '1;
		end else if (en && |grant) begin
			mask <= mask_nxt;
		end
	end

	a_grant_valid: assert property (@(posedge aclk) disable iff (!rst_n)
		$onehot0(grant) && ((grant & ~req) == '0));

endmodule

/* hdl/wbxb_bus_if.sv */
`timescale 1ns/1ps

interface wbxb_bus_if import wbxb_pkg::*; ();

	logic     cyc;
	logic     stb;
	logic     we;
	wb_addr_t adr;
	wb_data_t dat_w;
	wb_data_t dat_r;
	wb_sel_t  sel;
	logic     ack;   // one-cycle pulse.
	logic     err;   // one-cycle pulse.

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		output sel,
		input  dat_r,
		input  ack,
		input  err
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		input  sel,
		output dat_r,
		output ack,
		output err
	);

endinterface

/* hdl/wbxb_pkg.sv */
package wbxb_pkg;

	// ##########################################################################
	// bus geometry
	// ##########################################################################

	localparam int MST_NB = 4; // master ports.
	localparam int SLV_NB = 2; // internal ram slaves.

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8; // one select bit per byte lane.

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0]  wb_sel_t;

	typedef logic [$clog2(SLV_NB)-1:0] slv_idx_t;
	typedef logic [MST_NB-1:0]         mst_vec_t;

	// static arbitration level, 3 is the highest.
	typedef logic [1:0] prio_t;

	// ##########################################################################
	// address map
	// ##########################################################################

	// Each window is aligned to its span, so the low address bits
	// index the slave directly.
	localparam wb_addr_t SLV_BASE [SLV_NB] = '{
		32'h0000_0000, // slave 0.
		32'h0000_1000  // slave 1.
	};

	localparam wb_addr_t SLV_SPAN = 32'h0000_1000; // 1024 words.

endpackage
